// ==== src/exe_pkg.sv ====
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_lanes  = 2;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_slt = 4'd5,
        op_sll = 4'd6,
        op_srl = 4'd7,
        op_beq = 4'd8,
        op_bne = 4'd9,
        op_blt = 4'd10,
        op_jal = 4'd11,
        op_lw  = 4'd12,
        op_sw  = 4'd13,
        op_sb  = 4'd14
    } alu_op_e;

    // one decoded micro-op from dispatch
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               op;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic                  pred_taken;
        logic [xlen-1:0]       pred_target;
    } lane_uop_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               op;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic [xlen-1:0]       result;
        logic                  excp;
    } lane_res_t;

    typedef struct packed {
        logic            is_branch;
        logic            taken;
        logic [xlen-1:0] target;
        logic            mispredict;
    } branch_res_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [xlen-1:0] addr;
        logic [3:0]      wstrb;
        logic [xlen-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic            en;
        logic            taken;
        logic [xlen-1:0] target;
        logic [xlen-1:0] pc;
    } bpu_update_t;

endpackage

// ==== src/exe_alu.sv ====
`timescale 1ns/100ps

module exe_alu (
    input  exe_pkg::alu_op_e         op_i,
    input  logic [exe_pkg::xlen-1:0] a_i,
    input  logic [exe_pkg::xlen-1:0] b_i,
    input  logic [exe_pkg::xlen-1:0] pc_i,
    output logic [exe_pkg::xlen-1:0] result_o
);

    logic slt_bit;

    assign slt_bit = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            exe_pkg::op_add: result_o = a_i + b_i;
            exe_pkg::op_sub: result_o = a_i - b_i;
            exe_pkg::op_and: result_o = a_i & b_i;
            exe_pkg::op_or:  result_o = a_i | b_i;
            exe_pkg::op_xor: result_o = a_i ^ b_i;
            exe_pkg::op_slt: result_o = {{(exe_pkg::xlen-1){1'b0}}, slt_bit};
            exe_pkg::op_sll: result_o = a_i << b_i[4:0];
            exe_pkg::op_srl: result_o = a_i >> b_i[4:0];
            // link value
            exe_pkg::op_jal: result_o = pc_i + 32'd4;
            default:         result_o = '0;
        endcase
    end

endmodule

// ==== src/exe_branch_unit.sv ====
`timescale 1ns/100ps

module exe_branch_unit (
    input  exe_pkg::lane_uop_t   uop_i,
    output exe_pkg::branch_res_t branch_o
);

    logic cond;
    logic is_branch;

    assign is_branch = uop_i.valid &&
                       (uop_i.op inside {exe_pkg::op_beq, exe_pkg::op_bne,
                                         exe_pkg::op_blt, exe_pkg::op_jal});

    always_comb begin
        case (uop_i.op)
            exe_pkg::op_beq: cond = uop_i.src1 == uop_i.src2;
            exe_pkg::op_bne: cond = uop_i.src1 != uop_i.src2;
            exe_pkg::op_blt: cond = $signed(uop_i.src1) < $signed(uop_i.src2);
            exe_pkg::op_jal: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        branch_o.is_branch = is_branch;
        branch_o.taken     = is_branch && cond;
        branch_o.target    = branch_o.taken ? uop_i.pc + uop_i.imm : uop_i.pc + 32'd4;
        // wrong direction, or right direction to the wrong place
        branch_o.mispredict = is_branch &&
                              ((branch_o.taken != uop_i.pred_taken) ||
                               (branch_o.taken && branch_o.target != uop_i.pred_target));
    end

endmodule

// ==== src/exe_lane.sv ====
`timescale 1ns/100ps

module exe_lane (
    input  exe_pkg::lane_uop_t   uop_i,
    output exe_pkg::lane_res_t   res_o,
    output exe_pkg::branch_res_t branch_o,
    output exe_pkg::dcache_req_t req_o
);

    logic [exe_pkg::xlen-1:0] addr;
    logic [exe_pkg::xlen-1:0] alu_result;
    logic                     mem_op;
    logic                     misaligned;

    exe_alu u_alu (
        .op_i     (uop_i.op),
        .a_i      (uop_i.src1),
        .b_i      (uop_i.src2),
        .pc_i     (uop_i.pc),
        .result_o (alu_result)
    );

    exe_branch_unit u_branch (
        .uop_i    (uop_i),
        .branch_o (branch_o)
    );

    assign addr   = uop_i.src1 + uop_i.imm;
    assign mem_op = uop_i.valid &&
                    (uop_i.op inside {exe_pkg::op_lw, exe_pkg::op_sw, exe_pkg::op_sb});

    // only word accesses need 4-byte alignment
    assign misaligned = (uop_i.op inside {exe_pkg::op_lw, exe_pkg::op_sw}) &&
                        (addr[1:0] != 2'b00);

    always_comb begin
        req_o       = '0;
        req_o.valid = mem_op && !misaligned;
        req_o.addr  = addr;
        case (uop_i.op)
            exe_pkg::op_sw: begin
                req_o.we    = 1'b1;
                req_o.wstrb = 4'b1111;
                req_o.wdata = uop_i.src2;
            end
            exe_pkg::op_sb: begin
                req_o.we    = 1'b1;
                req_o.wstrb = 4'b0001 << addr[1:0];
                req_o.wdata = {4{uop_i.src2[7:0]}};
            end
            default: ;
        endcase
    end

    always_comb begin
        res_o.valid  = uop_i.valid;
        res_o.pc     = uop_i.pc;
        res_o.op     = uop_i.op;
        res_o.rd     = uop_i.rd;
        res_o.we     = uop_i.we;
        res_o.result = mem_op ? addr : alu_result;
        res_o.excp   = mem_op && misaligned;
    end

endmodule

// ==== src/exe_ctrl.sv ====
`timescale 1ns/100ps

module exe_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  exe_pkg::lane_res_t         res_i    [exe_pkg::num_lanes],
    input  exe_pkg::branch_res_t       branch_i [exe_pkg::num_lanes],
    input  exe_pkg::dcache_req_t       req_i    [exe_pkg::num_lanes],
    input  logic                       stall_i,
    input  logic                       dcache_ready_i,
    output exe_pkg::dcache_req_t       dcache_req_o,
    output logic                       pause_ex_o,
    output logic                       kill_lane1_o,
    output logic                       branch_flush_o,
    output logic [exe_pkg::xlen-1:0]   branch_target_o,
    output logic                       excp_flush_o,
    output exe_pkg::bpu_update_t       bpu_update_o
);

    logic lane0_mem;
    logic flush_ok;
    logic lane1_live;
    logic upd_en_next;
    logic upd_sel1;

    // lane 0 redirect or fault squashes its younger partner
    assign kill_lane1_o = res_i[0].valid && (branch_i[0].mispredict || res_i[0].excp);
    assign lane1_live   = !kill_lane1_o;

    assign lane0_mem = res_i[0].valid &&
                       (res_i[0].op inside {exe_pkg::op_lw, exe_pkg::op_sw, exe_pkg::op_sb});

    // lane 0 owns the port whenever it holds a memory op
    always_comb begin
        if (lane0_mem) begin
            dcache_req_o = req_i[0];
        end else if (lane1_live) begin
            dcache_req_o = req_i[1];
        end else begin
            dcache_req_o = '0;
        end
    end

    assign pause_ex_o = dcache_req_o.valid && !dcache_ready_i;

    // flushes only count once the pair actually leaves the stage
    assign flush_ok = !pause_ex_o && !stall_i;

    assign branch_flush_o = flush_ok &&
                            (branch_i[0].mispredict || (branch_i[1].mispredict && lane1_live));
    assign branch_target_o = branch_i[0].mispredict ? branch_i[0].target : branch_i[1].target;

    assign excp_flush_o = flush_ok && (res_i[0].excp || (res_i[1].excp && lane1_live));

    // predictor training prefers lane 0
    assign upd_sel1    = !branch_i[0].is_branch;
    assign upd_en_next = flush_ok &&
                         (branch_i[0].is_branch || (branch_i[1].is_branch && lane1_live));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bpu_update_o.en <= 1'b0;
        end else begin
            bpu_update_o.en <= upd_en_next;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_sel1) begin
            bpu_update_o.taken  <= branch_i[1].taken;
            bpu_update_o.target <= branch_i[1].target;
            bpu_update_o.pc     <= res_i[1].pc;
        end else begin
            bpu_update_o.taken  <= branch_i[0].taken;
            bpu_update_o.target <= branch_i[0].target;
            bpu_update_o.pc     <= res_i[0].pc;
        end
    end

endmodule

// ==== src/exe_mem_reg.sv ====
`timescale 1ns/100ps

module exe_mem_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               stall_i,
    input  logic               pause_i,
    input  logic               kill_lane1_i,
    input  exe_pkg::lane_res_t res_i [exe_pkg::num_lanes],
    output exe_pkg::lane_res_t mem_o [exe_pkg::num_lanes]
);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            mem_o[0] <= '0;
            mem_o[1] <= '0;
        end else if (stall_i) begin
            // downstream busy so hold
            mem_o[0] <= mem_o[0];
            mem_o[1] <= mem_o[1];
        end else if (pause_i) begin
            // cache not ready yet so send a bubble
            mem_o[0] <= '0;
            mem_o[1] <= '0;
        end else if (kill_lane1_i) begin
            mem_o[0] <= res_i[0];
            mem_o[1] <= '0;
        end else begin
            mem_o[0] <= res_i[0];
            mem_o[1] <= res_i[1];
        end
    end

endmodule

// ==== src/exe_stage.sv ====
`timescale 1ns/100ps

module exe_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  exe_pkg::lane_uop_t         lane_uop_i [exe_pkg::num_lanes],
    input  logic                       stall_i,
    input  logic                       flush_i,
    input  logic                       dcache_ready_i,
    output exe_pkg::dcache_req_t       dcache_req_o,
    output logic                       pause_ex_o,
    output logic                       branch_flush_o,
    output logic [exe_pkg::xlen-1:0]   branch_target_o,
    output logic                       excp_flush_o,
    output exe_pkg::bpu_update_t       bpu_update_o,
    output exe_pkg::lane_res_t         mem_o [exe_pkg::num_lanes]
);

    exe_pkg::lane_res_t   lane_res    [exe_pkg::num_lanes];
    exe_pkg::branch_res_t lane_branch [exe_pkg::num_lanes];
    exe_pkg::dcache_req_t lane_req    [exe_pkg::num_lanes];
    logic                 kill_lane1;

    for (genvar i = 0; i < exe_pkg::num_lanes; i++) begin : g_lane
        exe_lane u_lane (
            .uop_i    (lane_uop_i[i]),
            .res_o    (lane_res[i]),
            .branch_o (lane_branch[i]),
            .req_o    (lane_req[i])
        );
    end

    exe_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .res_i           (lane_res),
        .branch_i        (lane_branch),
        .req_i           (lane_req),
        .stall_i         (stall_i),
        .dcache_ready_i  (dcache_ready_i),
        .dcache_req_o    (dcache_req_o),
        .pause_ex_o      (pause_ex_o),
        .kill_lane1_o    (kill_lane1),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o),
        .excp_flush_o    (excp_flush_o),
        .bpu_update_o    (bpu_update_o)
    );

    exe_mem_reg u_mem_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .pause_i      (pause_ex_o),
        .kill_lane1_i (kill_lane1),
        .res_i        (lane_res),
        .mem_o        (mem_o)
    );

endmodule

// ==== testbench/tb_exe_stage.sv ====
`timescale 1ns/100ps

module tb_exe_stage;

    logic                 clk = 1'b0;
    logic                 rst_n_i;
    exe_pkg::lane_uop_t   lane_uop_i [exe_pkg::num_lanes];
    logic                 stall_i;
    logic                 flush_i;
    logic                 dcache_ready_i;
    exe_pkg::dcache_req_t dcache_req_o;
    logic                 pause_ex_o;
    logic                 branch_flush_o;
    logic [31:0]          branch_target_o;
    logic                 excp_flush_o;
    exe_pkg::bpu_update_t bpu_update_o;
    exe_pkg::lane_res_t   mem_o [exe_pkg::num_lanes];

    // shadow copies of the registered outputs
    exe_pkg::lane_res_t   mem_exp [exe_pkg::num_lanes];
    exe_pkg::bpu_update_t bpu_exp;
    logic                 hold_pair;
    logic [31:0]          lfsr = 32'd18;
    int                   errors = 0;
    int                   tests_ok = 0;
    int                   tests_bad = 0;
    int                   cycles = 0;
    int                   cycle_limit;
    int                   alu_len = 200;
    int                   run_len = 300;

    exe_stage dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
        assert (got === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    // kind 0 alu, 1 branch, 2 memory
    function automatic exe_pkg::lane_uop_t make_uop(input int kind);
        exe_pkg::lane_uop_t u;
        logic [3:0]         opc;
        u = '0;
        u.valid = rand_bits(4) != 0;
        u.pc = rand_bits(14) << 2;
        u.rd = 5'(rand_bits(5));
        u.we = rand_bits(1) != 0;
        u.src1 = rand_bits(32);
        u.src2 = rand_bits(32);
        if (kind == 0) begin
            opc = 4'(rand_bits(3));
        end else if (kind == 1) begin
            opc = 4'(8 + rand_bits(2));
            // small operands so that equal compares happen
            if (rand_bits(1) != 0) begin
                u.src1 = rand_bits(2);
                u.src2 = rand_bits(2);
            end
            u.imm = rand_bits(10) << 2;
            u.pred_taken = rand_bits(1) != 0;
            u.pred_target = (rand_bits(1) != 0) ? u.pc + u.imm : rand_bits(32);
        end else begin
            opc = 4'(12 + rand_bits(1) + rand_bits(1));
            u.imm = rand_bits(8);
            if (opc != 4'd14 && rand_bits(2) != 0) begin
                u.src1[1:0] = 2'b00;
                u.imm[1:0] = 2'b00;
            end
        end
        u.op = exe_pkg::alu_op_e'(opc);
        return u;
    endfunction

    task automatic model_lane(input exe_pkg::lane_uop_t u, output exe_pkg::lane_res_t r,
                              output exe_pkg::branch_res_t b, output exe_pkg::dcache_req_t q);
        logic [31:0] addr;
        logic [31:0] alu;
        logic        is_mem;
        logic        cond;
        addr = u.src1 + u.imm;
        is_mem = u.valid && (u.op inside {exe_pkg::op_lw, exe_pkg::op_sw, exe_pkg::op_sb});
        case (u.op)
            exe_pkg::op_add: alu = u.src1 + u.src2;
            exe_pkg::op_sub: alu = u.src1 - u.src2;
            exe_pkg::op_and: alu = u.src1 & u.src2;
            exe_pkg::op_or:  alu = u.src1 | u.src2;
            exe_pkg::op_xor: alu = u.src1 ^ u.src2;
            exe_pkg::op_slt: alu = {31'd0, $signed(u.src1) < $signed(u.src2)};
            exe_pkg::op_sll: alu = u.src1 << u.src2[4:0];
            exe_pkg::op_srl: alu = u.src1 >> u.src2[4:0];
            exe_pkg::op_jal: alu = u.pc + 32'd4;
            default:         alu = '0;
        endcase
        cond = (u.op == exe_pkg::op_beq && u.src1 == u.src2) ||
               (u.op == exe_pkg::op_bne && u.src1 != u.src2) ||
               (u.op == exe_pkg::op_blt && $signed(u.src1) < $signed(u.src2)) ||
               u.op == exe_pkg::op_jal;
        b.is_branch = u.valid && (u.op inside {exe_pkg::op_beq, exe_pkg::op_bne,
                                               exe_pkg::op_blt, exe_pkg::op_jal});
        b.taken = b.is_branch && cond;
        b.target = b.taken ? u.pc + u.imm : u.pc + 32'd4;
        b.mispredict = b.is_branch && (b.taken != u.pred_taken ||
                                       (b.taken && b.target != u.pred_target));
        r = '{u.valid, u.pc, u.op, u.rd, u.we, is_mem ? addr : alu, 1'b0};
        r.excp = is_mem && u.op != exe_pkg::op_sb && addr[1:0] != 2'b00;
        q = '0;
        q.valid = is_mem && !r.excp;
        q.addr = addr;
        if (u.op == exe_pkg::op_sw) begin
            q.we = 1'b1;
            q.wstrb = 4'hf;
            q.wdata = u.src2;
        end else if (u.op == exe_pkg::op_sb) begin
            q.we = 1'b1;
            q.wstrb = 4'b0001 << addr[1:0];
            q.wdata = {4{u.src2[7:0]}};
        end
    endtask

    task automatic check_regs();
        check_val("mem_o[0]", 128'(mem_exp[0]), 128'(mem_o[0]));
        check_val("mem_o[1]", 128'(mem_exp[1]), 128'(mem_o[1]));
        check_val("bpu_update_o.en", 128'(bpu_exp.en), 128'(bpu_update_o.en));
        if (bpu_exp.en) check_val("bpu_update_o", 128'(bpu_exp), 128'(bpu_update_o));
    endtask

    // same-cycle outputs and the state after the coming edge
    task automatic model_cycle();
        exe_pkg::lane_res_t   r [2];
        exe_pkg::branch_res_t b [2];
        exe_pkg::dcache_req_t q [2];
        exe_pkg::dcache_req_t req;
        logic                 kill;
        logic                 pause;
        logic                 ok;
        logic                 bflush;
        int                   sel;
        model_lane(lane_uop_i[0], r[0], b[0], q[0]);
        model_lane(lane_uop_i[1], r[1], b[1], q[1]);
        kill = r[0].valid && (b[0].mispredict || r[0].excp);
        if (r[0].valid && (r[0].op inside {exe_pkg::op_lw, exe_pkg::op_sw, exe_pkg::op_sb}))
            req = q[0];
        else if (!kill)
            req = q[1];
        else
            req = '0;
        pause = req.valid && !dcache_ready_i;
        ok = !pause && !stall_i;
        bflush = ok && (b[0].mispredict || (b[1].mispredict && !kill));
        check_val("dcache_req_o.valid", 128'(req.valid), 128'(dcache_req_o.valid));
        if (req.valid) check_val("dcache_req_o", 128'(req), 128'(dcache_req_o));
        check_val("pause_ex_o", 128'(pause), 128'(pause_ex_o));
        check_val("branch_flush_o", 128'(bflush), 128'(branch_flush_o));
        if (bflush) begin
            check_val("branch_target_o", 128'(b[0].mispredict ? b[0].target : b[1].target),
                      128'(branch_target_o));
        end
        check_val("excp_flush_o", 128'(ok && (r[0].excp || (r[1].excp && !kill))),
                  128'(excp_flush_o));
        sel = b[0].is_branch ? 0 : 1;
        bpu_exp = '{rst_n_i && ok && (b[0].is_branch || (b[1].is_branch && !kill)),
                    b[sel].taken, b[sel].target, r[sel].pc};
        if (!rst_n_i || flush_i || (!stall_i && pause)) begin
            mem_exp[0] = '0;
            mem_exp[1] = '0;
        end else if (!stall_i) begin
            mem_exp[0] = r[0];
            mem_exp[1] = kill ? '0 : r[1];
        end
        hold_pair = pause || stall_i;
    endtask

    // the last rst_cycles cycles of a test run with reset held low
    task automatic run_test(input string name, input int len, input int kind,
                            input bit rnd_ready, input bit rnd_ctl, input int rst_cycles);
        int err0;
        int k [2];
        err0 = errors;
        for (int c = 0; c < len; c++) begin
            rst_n_i = c < len - rst_cycles;
            if (!rst_n_i) begin
                lane_uop_i[0] = '0;
                lane_uop_i[1] = '0;
                stall_i = 1'b0;
                flush_i = 1'b0;
                dcache_ready_i = 1'b1;
            end else begin
                if (!hold_pair) begin
                    k[0] = kind;
                    k[1] = (kind == 2) ? 0 : kind;
                    if (kind == 2 && rand_bits(1) != 0) begin
                        k[0] = 0;
                        k[1] = 2;
                    end else if (kind == 3) begin
                        k[0] = rand_bits(2) % 3;
                        k[1] = rand_bits(2) % 3;
                    end
                    // never two memory ops in one pair
                    if (k[0] == 2 && k[1] == 2) k[1] = 0;
                    lane_uop_i[0] = make_uop(k[0]);
                    lane_uop_i[1] = make_uop(k[1]);
                end
                dcache_ready_i = !rnd_ready || rand_bits(1) != 0;
                stall_i = rnd_ctl && rand_bits(2) == 0;
                flush_i = rnd_ctl && rand_bits(3) == 0;
            end
            #1;
            model_cycle();
            @(negedge clk);
            check_regs();
        end
        if (errors == err0) begin
            tests_ok++;
            $display("test %s: pass, %0d cycles", name, len);
        end else begin
            tests_bad++;
            $display("test %s: fail, %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        dcache_ready_i = 1'b1;
        lane_uop_i[0] = '0;
        lane_uop_i[1] = '0;
        mem_exp[0] = '0;
        mem_exp[1] = '0;
        bpu_exp = '0;
        hold_pair = 1'b0;
        cycle_limit = 16 + alu_len + 5 * run_len + 32;
        @(negedge clk);
        run_test("reset", 16, 0, 0, 0, 16);
        run_test("alu_lanes", alu_len, 0, 0, 0, 0);
        run_test("branch_resolve", run_len, 1, 0, 0, 0);
        run_test("load_store", run_len, 2, 0, 0, 0);
        run_test("cache_backpressure", run_len, 2, 1, 0, 0);
        run_test("stall_flush_reset", run_len, 3, 1, 1, 8);
        run_test("predictor_update", run_len, 3, 1, 1, 0);
        $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== exe_stage.f ====
src/exe_pkg.sv
src/exe_alu.sv
src/exe_branch_unit.sv
src/exe_lane.sv
src/exe_ctrl.sv
src/exe_mem_reg.sv
src/exe_stage.sv
testbench/tb_exe_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exe_stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_exe_stage -f exe_stage.f -Mdir obj_dir
out=$(./obj_dir/Vtb_exe_stage)
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
